/* design/sao_macros.svh */
`ifndef SAO_MACROS_SVH
`define SAO_MACROS_SVH

// Sample and position widths
`define PIXEL_W     8
`define COORD_W     7
`define LCU_IDX_W   3
`define ADDR_W      14

// Offset and band fields
`define OFFSET_W    4
`define BAND_POS_W  5

// 128x128 image
`define IMG_W       128
`define PIXEL_MAX   255

`endif

/* design/sao_pkg.sv */
`default_nettype none

`include "sao_macros.svh"

package sao_pkg;

    typedef logic [`PIXEL_W-1:0]    pixel_t;
    typedef logic [`COORD_W-1:0]    coord_t;    // Column or row inside a block
    typedef logic [`LCU_IDX_W-1:0]  lcu_idx_t;
    typedef logic [`ADDR_W-1:0]     addr_t;     // Raster address in the image
    typedef logic [`OFFSET_W-1:0]   offset_t;
    typedef logic [`BAND_POS_W-1:0] band_t;

    // Filter mode of one block
    typedef enum logic [1:0] {
        MODE_OFF,
        MODE_BAND,
        MODE_EDGE
    } sao_mode_e;

    // Input scanner phase
    typedef enum logic [1:0] {
        IDLE,       // Waiting for the first pixel of a block
        RUN,
        ROW_FLUSH,  // Edge mode, emits the last pixel of a row
        LCU_DRAIN
    } scan_state_e;

endpackage

`default_nettype wire

/* design/sao_ifs.sv */
`default_nettype none

// Block settings, held until the block has drained
interface lcu_cfg_if;
    sao_pkg::sao_mode_e         mode;
    sao_pkg::band_t             band_pos;
    sao_pkg::offset_t [0:3]     offset;     // offset[0] is the top nibble
    sao_pkg::lcu_idx_t          lcu_x;
    sao_pkg::lcu_idx_t          lcu_y;
    sao_pkg::coord_t            last_coord; // Block side minus one

    modport source (output mode, band_pos, offset, lcu_x, lcu_y, last_coord);
    modport sink (input mode, band_pos, offset, lcu_x, lcu_y, last_coord);
endinterface

// One sample with its horizontal neighbours
interface sample_if;
    logic               valid;
    sao_pkg::pixel_t    center;
    sao_pkg::pixel_t    left;
    sao_pkg::pixel_t    right;
    sao_pkg::coord_t    x;
    sao_pkg::coord_t    y;
    logic               boundary;   // First or last column

    modport source (output valid, center, left, right, x, y, boundary);
    modport sink (input valid, center, left, right, x, y, boundary);
endinterface

// Filtered pixel with its block position
interface pixel_if;
    logic               valid;
    sao_pkg::pixel_t    pixel;
    sao_pkg::coord_t    x;
    sao_pkg::coord_t    y;

    modport source (output valid, pixel, x, y);
    modport sink (input valid, pixel, x, y);
endinterface

`default_nettype wire

/* design/sao_scanner.sv */
`default_nettype none

module sao_scanner (
    input  wire logic               clk,
    input  wire logic               reset,
    input  wire logic               in_en,
    input  wire sao_pkg::pixel_t    din,
    input  wire logic [1:0]         ipf_type,
    input  wire sao_pkg::band_t     ipf_band_pos,
    input  wire logic               ipf_wo_class,
    input  wire logic [15:0]        ipf_offset,
    input  wire sao_pkg::lcu_idx_t  lcu_x,
    input  wire sao_pkg::lcu_idx_t  lcu_y,
    input  wire logic [1:0]         lcu_size,
    output logic                    busy,
    lcu_cfg_if.source               cfg,
    sample_if.source                smp
);

    sao_pkg::scan_state_e   state;
    sao_pkg::coord_t        col;
    sao_pkg::coord_t        row;
    logic [1:0]             phase_cnt;

    sao_pkg::sao_mode_e     in_mode;
    sao_pkg::coord_t        in_last;
    sao_pkg::sao_mode_e     cur_mode;
    sao_pkg::coord_t        cur_last;
    logic                   accept;
    logic                   flush_emit;

    // Edge window, the pending pixel and the one left of it
    sao_pkg::pixel_t        win_prev;
    sao_pkg::pixel_t        win_cur;
    sao_pkg::coord_t        win_x;
    sao_pkg::coord_t        win_y;

    logic                   emit;
    sao_pkg::pixel_t        e_center;
    sao_pkg::pixel_t        e_left;
    sao_pkg::pixel_t        e_right;
    sao_pkg::coord_t        e_x;
    sao_pkg::coord_t        e_y;

    always_comb begin
        case (ipf_type)
            2'd0:    in_mode = sao_pkg::MODE_OFF;
            2'd2:    in_mode = ipf_wo_class ? sao_pkg::MODE_OFF : sao_pkg::MODE_EDGE;
            default: in_mode = sao_pkg::MODE_BAND;
        endcase
        case (lcu_size)
            2'd0:    in_last = 7'd15;
            2'd1:    in_last = 7'd31;
            default: in_last = 7'd63;
        endcase
    end

    // Settings of the block in flight, or of the one just starting
    assign cur_mode = (state == sao_pkg::IDLE) ? in_mode : cfg.mode;
    assign cur_last = (state == sao_pkg::IDLE) ? in_last : cfg.last_coord;

    assign accept = in_en && (state == sao_pkg::IDLE || state == sao_pkg::RUN);
    assign busy = (state == sao_pkg::ROW_FLUSH) || (state == sao_pkg::LCU_DRAIN);

    assign flush_emit = busy && (phase_cnt == 2'd0) && (cfg.mode == sao_pkg::MODE_EDGE);

    always_comb begin
        emit = 1'b0;
        e_center = din;
        e_left = din;
        e_right = din;
        e_x = col;
        e_y = row;
        if (accept) begin
            if (cur_mode != sao_pkg::MODE_EDGE) begin
                emit = 1'b1;
            end
            else if (col != '0) begin  // New pixel completes the window
                emit = 1'b1;
                e_center = win_cur;
                e_left = win_prev;
                e_x = win_x;
                e_y = win_y;
            end
        end
        else if (flush_emit) begin
            emit = 1'b1;
            e_center = win_cur;
            e_left = win_prev;
            e_right = win_cur;  // No right neighbour at the row end
            e_x = win_x;
            e_y = win_y;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= sao_pkg::IDLE;
            col <= '0;
            row <= '0;
            phase_cnt <= '0;
            smp.valid <= 1'b0;
        end
        else begin
            smp.valid <= emit;
            case (state)
                sao_pkg::IDLE, sao_pkg::RUN: begin
                    if (accept) begin
                        phase_cnt <= '0;
                        if (col == cur_last) begin
                            col <= '0;
                            if (row == cur_last) begin
                                row <= '0;
                                state <= sao_pkg::LCU_DRAIN;
                            end
                            else begin
                                row <= row + 1'b1;
                                state <= (cur_mode == sao_pkg::MODE_EDGE) ?
                                         sao_pkg::ROW_FLUSH : sao_pkg::RUN;
                            end
                        end
                        else begin
                            col <= col + 1'b1;
                            state <= sao_pkg::RUN;
                        end
                    end
                end
                sao_pkg::ROW_FLUSH: begin
                    phase_cnt <= phase_cnt + 1'b1;
                    if (phase_cnt == 2'd1) begin
                        state <= sao_pkg::RUN;
                    end
                end
                sao_pkg::LCU_DRAIN: begin
                    phase_cnt <= phase_cnt + 1'b1;
                    if (phase_cnt == 2'd3) begin
                        state <= sao_pkg::IDLE;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept && state == sao_pkg::IDLE) begin
            cfg.mode <= in_mode;
            cfg.band_pos <= ipf_band_pos;
            cfg.offset <= ipf_offset;
            cfg.lcu_x <= lcu_x;
            cfg.lcu_y <= lcu_y;
            cfg.last_coord <= in_last;
        end
        if (accept) begin
            win_prev <= win_cur;
            win_cur <= din;
            win_x <= col;
            win_y <= row;
        end
        if (emit) begin
            smp.center <= e_center;
            smp.left <= e_left;
            smp.right <= e_right;
            smp.x <= e_x;
            smp.y <= e_y;
            smp.boundary <= (e_x == '0) || (e_x == cur_last);
        end
    end

endmodule

`default_nettype wire

/* design/sao_classifier.sv */
`default_nettype none

`include "sao_macros.svh"

module sao_classifier (
    input  wire logic   clk,
    input  wire logic   reset,
    lcu_cfg_if.sink     cfg,
    sample_if.sink      smp,
    pixel_if.source     pix
);

    sao_pkg::band_t                 band;
    logic                           near_band;
    logic [`PIXEL_W:0]              twice_c;
    logic [`PIXEL_W:0]              nb_sum;
    logic                           apply;
    logic [1:0]                     sel;
    sao_pkg::offset_t               off;
    logic signed [`PIXEL_W+1:0]     off_ext;
    logic signed [`PIXEL_W+1:0]     sum;
    sao_pkg::pixel_t                result;

    assign band = smp.center[`PIXEL_W-1 -: `BAND_POS_W];  // Pixel / 8

    // Band equal to band_pos or one either side, no wrap at 0 or 31
    assign near_band = (band == cfg.band_pos) ||
                       ({1'b0, band} == {1'b0, cfg.band_pos} + 1'b1) ||
                       ({1'b0, band} + 1'b1 == {1'b0, cfg.band_pos});

    assign twice_c = {smp.center, 1'b0};
    assign nb_sum = {1'b0, smp.left} + {1'b0, smp.right};

    always_comb begin
        apply = 1'b0;
        sel = 2'd0;
        case (cfg.mode)
            sao_pkg::MODE_BAND: begin
                apply = !near_band;
                sel = band[1:0];
            end
            sao_pkg::MODE_EDGE: begin
                if (smp.boundary) begin
                    apply = 1'b0;
                end
                else if (smp.center < smp.left && smp.center < smp.right) begin
                    apply = 1'b1;   // Local minimum
                    sel = 2'd0;
                end
                else if (smp.center > smp.left && smp.center > smp.right) begin
                    apply = 1'b1;   // Local maximum
                    sel = 2'd3;
                end
                else if (twice_c < nb_sum) begin
                    apply = 1'b1;
                    sel = 2'd1;
                end
                else if (twice_c > nb_sum) begin
                    apply = 1'b1;
                    sel = 2'd2;
                end
            end
            default: apply = 1'b0;
        endcase
    end

    // Offsets 2 and 3 are signed
    assign off = cfg.offset[sel];
    assign off_ext = sel[1] ? {{(`PIXEL_W+2-`OFFSET_W){off[`OFFSET_W-1]}}, off} :
                              {{(`PIXEL_W+2-`OFFSET_W){1'b0}}, off};
    assign sum = $signed({2'b00, smp.center}) + off_ext;

    always_comb begin
        if (!apply) begin
            result = smp.center;
        end
        else if (sum < 0) begin
            result = '0;
        end
        else if (sum > `PIXEL_MAX) begin
            result = `PIXEL_W'(`PIXEL_MAX);
        end
        else begin
            result = sum[`PIXEL_W-1:0];
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pix.valid <= 1'b0;
        end
        else begin
            pix.valid <= smp.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (smp.valid) begin
            pix.pixel <= result;
            pix.x <= smp.x;
            pix.y <= smp.y;
        end
    end

endmodule

`default_nettype wire

/* design/sao_writer.sv */
`default_nettype none

`include "sao_macros.svh"

module sao_writer (
    input  wire logic           clk,
    input  wire logic           reset,
    lcu_cfg_if.sink             cfg,
    pixel_if.sink               pix,
    output logic                out_en,
    output sao_pkg::pixel_t     dout,
    output sao_pkg::addr_t      dout_addr,
    output logic                finish
);

    localparam sao_pkg::addr_t LAST_ADDR = `ADDR_W'(`IMG_W * `IMG_W - 1);

    sao_pkg::addr_t side;
    sao_pkg::addr_t row_abs;
    sao_pkg::addr_t col_abs;
    sao_pkg::addr_t addr;

    assign side = sao_pkg::addr_t'(cfg.last_coord) + 1'b1;
    assign row_abs = side * sao_pkg::addr_t'(cfg.lcu_y) + sao_pkg::addr_t'(pix.y);
    assign col_abs = side * sao_pkg::addr_t'(cfg.lcu_x) + sao_pkg::addr_t'(pix.x);
    assign addr = row_abs * `ADDR_W'(`IMG_W) + col_abs;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            out_en <= 1'b0;
            finish <= 1'b0;
        end
        else begin
            out_en <= pix.valid;
            finish <= out_en && (dout_addr == LAST_ADDR);  // Last pixel of the image
        end
    end

    always_ff @(posedge clk) begin
        if (pix.valid) begin
            dout <= pix.pixel;
            dout_addr <= addr;
        end
    end

endmodule

`default_nettype wire

/* design/sao_filter.sv */
`default_nettype none

module sao_filter (
    input  wire logic               clk,
    input  wire logic               reset,
    input  wire logic               in_en,
    input  wire sao_pkg::pixel_t    din,
    input  wire logic [1:0]         ipf_type,
    input  wire sao_pkg::band_t     ipf_band_pos,
    input  wire logic               ipf_wo_class,
    input  wire logic [15:0]        ipf_offset,
    input  wire sao_pkg::lcu_idx_t  lcu_x,
    input  wire sao_pkg::lcu_idx_t  lcu_y,
    input  wire logic [1:0]         lcu_size,
    output logic                    busy,
    output logic                    out_en,
    output sao_pkg::pixel_t         dout,
    output sao_pkg::addr_t          dout_addr,
    output logic                    finish
);

    lcu_cfg_if cfg_if ();
    sample_if  smp_if ();
    pixel_if   pix_if ();

    // Pixel source side, window and flow control
    sao_scanner sao_scanner_inst (
        .clk          (clk),
        .reset        (reset),
        .in_en        (in_en),
        .din          (din),
        .ipf_type     (ipf_type),
        .ipf_band_pos (ipf_band_pos),
        .ipf_wo_class (ipf_wo_class),
        .ipf_offset   (ipf_offset),
        .lcu_x        (lcu_x),
        .lcu_y        (lcu_y),
        .lcu_size     (lcu_size),
        .busy         (busy),
        .cfg          (cfg_if.source),
        .smp          (smp_if.source)
    );

    sao_classifier sao_classifier_inst (
        .clk   (clk),
        .reset (reset),
        .cfg   (cfg_if.sink),
        .smp   (smp_if.sink),
        .pix   (pix_if.source)
    );

    // Address and output registers
    sao_writer sao_writer_inst (
        .clk       (clk),
        .reset     (reset),
        .cfg       (cfg_if.sink),
        .pix       (pix_if.sink),
        .out_en    (out_en),
        .dout      (dout),
        .dout_addr (dout_addr),
        .finish    (finish)
    );

endmodule

`default_nettype wire

/* verification/sao_ref_model.svh */
`ifndef SAO_REF_MODEL_SVH
`define SAO_REF_MODEL_SVH

// Next value of the pixel and gap generator
function automatic logic [31:0] lcg_step(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
endfunction

function automatic int block_side(input logic [1:0] lcu_size);
    case (lcu_size)
        2'd0:    return 16;
        2'd1:    return 32;
        default: return 64;
    endcase
endfunction

function automatic sao_pkg::sao_mode_e expected_mode(input logic [1:0] ipf_type,
                                                     input logic wo_class);
    if (ipf_type == 2'd0) begin
        return sao_pkg::MODE_OFF;
    end
    if (ipf_type == 2'd2) begin
        return wo_class ? sao_pkg::MODE_OFF : sao_pkg::MODE_EDGE;  // No class falls back to off
    end
    return sao_pkg::MODE_BAND;
endfunction

// Offset 0 sits in the top nibble, 2 and 3 are signed
function automatic int offset_value(input logic [15:0] offs, input int k);
    logic [3:0] nib;
    nib = offs[15 - 4 * k -: 4];
    if (k >= 2) begin
        return int'($signed(nib));
    end
    return int'(nib);
endfunction

function automatic sao_pkg::pixel_t add_clipped(input sao_pkg::pixel_t p, input int off);
    int v;
    v = int'(p) + off;
    if (v < 0) begin
        v = 0;
    end
    else if (v > 255) begin
        v = 255;
    end
    return sao_pkg::pixel_t'(v);
endfunction

function automatic sao_pkg::pixel_t band_pixel(input sao_pkg::pixel_t p,
                                               input sao_pkg::band_t band_pos,
                                               input logic [15:0] offs);
    int band;
    int bp;
    band = int'(p) / 8;
    bp = int'(band_pos);
    if (band == bp || band == bp + 1 || band + 1 == bp) begin
        return p;
    end
    return add_clipped(p, offset_value(offs, band % 4));
endfunction

// Interior column only, boundary columns pass unchanged
function automatic sao_pkg::pixel_t edge_pixel(input sao_pkg::pixel_t c,
                                               input sao_pkg::pixel_t l,
                                               input sao_pkg::pixel_t r,
                                               input logic [15:0] offs);
    int ci;
    int li;
    int ri;
    ci = int'(c);
    li = int'(l);
    ri = int'(r);
    if (ci < li && ci < ri) return add_clipped(c, offset_value(offs, 0));
    if (ci > li && ci > ri) return add_clipped(c, offset_value(offs, 3));
    if (2 * ci < li + ri) return add_clipped(c, offset_value(offs, 1));
    if (2 * ci > li + ri) return add_clipped(c, offset_value(offs, 2));
    return c;
endfunction

function automatic sao_pkg::addr_t pixel_addr(input sao_pkg::lcu_idx_t lx,
                                              input sao_pkg::lcu_idx_t ly,
                                              input int side, input int x, input int y);
    return sao_pkg::addr_t'((side * int'(ly) + y) * 128 + side * int'(lx) + x);
endfunction

`endif

/* verification/tb_sao_filter.sv */
`default_nettype none

module tb_sao_filter;

    `include "sao_ref_model.svh"

    localparam int PAT_RANDOM = 0;
    localparam int PAT_RAMP = 1;
    localparam int PAT_CONST = 2;
    localparam int PAT_EXTREME = 3;    // Random values near 0 and 255
    localparam int NUM_CASES = 11;
    localparam sao_pkg::addr_t LAST_ADDR = sao_pkg::addr_t'(128 * 128 - 1);

    typedef struct {
        logic [1:0]         ipf_type;
        logic               wo_class;
        logic [1:0]         lcu_size;
        sao_pkg::lcu_idx_t  lx;
        sao_pkg::lcu_idx_t  ly;
        sao_pkg::band_t     band_pos;
        logic [15:0]        offsets;
        int                 pattern;
        logic               gaps;
    } case_t;

    logic               clk;
    logic               reset;
    logic               in_en;
    sao_pkg::pixel_t    din;
    logic [1:0]         ipf_type;
    sao_pkg::band_t     ipf_band_pos;
    logic               ipf_wo_class;
    logic [15:0]        ipf_offset;
    sao_pkg::lcu_idx_t  lcu_x;
    sao_pkg::lcu_idx_t  lcu_y;
    logic [1:0]         lcu_size;
    logic               busy;
    logic               out_en;
    sao_pkg::pixel_t    dout;
    sao_pkg::addr_t     dout_addr;
    logic               finish;

    case_t              cases [NUM_CASES];
    sao_pkg::pixel_t    blk [0:4095];
    sao_pkg::pixel_t    exp_pix_q [$];
    sao_pkg::addr_t     exp_addr_q [$];
    int                 lat_q [$];     // Drive cycle, -1 where latency varies
    logic [31:0]        seed = 32'hc30478d6;
    int                 cycle = 0;
    int                 busy_left = 0;
    int                 finish_cnt = 0;
    logic               last_addr_out = 1'b0;

    sao_filter sao_filter_inst (
        .clk          (clk),
        .reset        (reset),
        .in_en        (in_en),
        .din          (din),
        .ipf_type     (ipf_type),
        .ipf_band_pos (ipf_band_pos),
        .ipf_wo_class (ipf_wo_class),
        .ipf_offset   (ipf_offset),
        .lcu_x        (lcu_x),
        .lcu_y        (lcu_y),
        .lcu_size     (lcu_size),
        .busy         (busy),
        .out_en       (out_en),
        .dout         (dout),
        .dout_addr    (dout_addr),
        .finish       (finish)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) cycle <= cycle + 1;

    task automatic end_with_failure(input string line);
        $display("%s", line);
        $display("TESTBENCH FAILED");
        $fatal(1, "run stopped");
    endtask

    task automatic check_pixel(input sao_pkg::pixel_t got, input sao_pkg::pixel_t exp,
                               input sao_pkg::addr_t at);
        if (got !== exp) begin
            end_with_failure($sformatf("ERR %0t: pixel at address %0d is %0d, expected %0d",
                                       $time, at, got, exp));
        end
    endtask

    task automatic check_addr(input sao_pkg::addr_t got, input sao_pkg::addr_t exp);
        if (got !== exp) begin
            end_with_failure($sformatf("ERR %0t: output address %0d, expected %0d",
                                       $time, got, exp));
        end
    endtask

    task automatic check_finish(input logic got, input logic exp);
        if (got !== exp) begin
            end_with_failure($sformatf("ERR %0t: finish is %b, expected %b", $time, got, exp));
        end
    endtask

    task automatic check_busy(input logic got, input logic exp);
        if (got !== exp) begin
            end_with_failure($sformatf("ERR %0t: busy is %b, expected %b", $time, got, exp));
        end
    endtask

    task automatic check_latency(input int got, input int exp, input sao_pkg::addr_t at);
        if (got != exp) begin
            end_with_failure($sformatf("ERR %0t: address %0d came out after %0d cycles, expected %0d",
                                       $time, at, got, exp));
        end
    endtask

    function automatic case_t make_case(input logic [1:0] t, input logic wo,
                                        input logic [1:0] size, input int lx, input int ly,
                                        input int bp, input logic [15:0] offs, input int pat,
                                        input logic gaps);
        case_t r;
        r.ipf_type = t;
        r.wo_class = wo;
        r.lcu_size = size;
        r.lx = sao_pkg::lcu_idx_t'(lx);
        r.ly = sao_pkg::lcu_idx_t'(ly);
        r.band_pos = sao_pkg::band_t'(bp);
        r.offsets = offs;
        r.pattern = pat;
        r.gaps = gaps;
        return r;
    endfunction

    // type, wo_class, size, lcu x/y, band_pos, offsets, pattern, gaps
    task automatic load_cases();
        cases[0] = make_case(2'd0, 1'b0, 2'd0, 2, 3, 0, 16'h0000, PAT_RANDOM, 1'b0);
        cases[1] = make_case(2'd1, 1'b0, 2'd0, 0, 0, 10, 16'h759c, PAT_RANDOM, 1'b1);
        cases[2] = make_case(2'd3, 1'b0, 2'd1, 3, 0, 0, 16'h3f87, PAT_EXTREME, 1'b0);
        cases[3] = make_case(2'd2, 1'b0, 2'd1, 1, 0, 0, 16'ha69b, PAT_RANDOM, 1'b1);
        cases[4] = make_case(2'd2, 1'b0, 2'd1, 2, 1, 0, 16'hf5cb, PAT_RAMP, 1'b0);
        cases[5] = make_case(2'd2, 1'b0, 2'd0, 4, 5, 0, 16'hf3e8, PAT_EXTREME, 1'b1);
        cases[6] = make_case(2'd2, 1'b1, 2'd0, 5, 6, 0, 16'h5555, PAT_RANDOM, 1'b0);
        // Whole image in four blocks
        cases[7] = make_case(2'd0, 1'b0, 2'd2, 0, 0, 0, 16'h0000, PAT_CONST, 1'b0);
        cases[8] = make_case(2'd0, 1'b0, 2'd2, 1, 0, 0, 16'h0000, PAT_RAMP, 1'b1);
        cases[9] = make_case(2'd0, 1'b0, 2'd2, 0, 1, 0, 16'h0000, PAT_RANDOM, 1'b0);
        cases[10] = make_case(2'd0, 1'b0, 2'd2, 1, 1, 0, 16'h0000, PAT_RANDOM, 1'b1);
    endtask

    // Fills the block and queues its expected outputs in raster order
    task automatic build_block(input int c);
        int side;
        int x;
        int y;
        sao_pkg::sao_mode_e mode;
        sao_pkg::pixel_t p;
        sao_pkg::pixel_t e;
        side = block_side(cases[c].lcu_size);
        mode = expected_mode(cases[c].ipf_type, cases[c].wo_class);
        for (y = 0; y < side; y++) begin
            for (x = 0; x < side; x++) begin
                seed = lcg_step(seed);
                case (cases[c].pattern)
                    PAT_RAMP:    p = sao_pkg::pixel_t'(x * 13 + y * 5);
                    PAT_CONST:   p = 8'd156;
                    PAT_EXTREME: p = seed[31] ? {5'b11111, seed[26:24]} : {5'b00000, seed[26:24]};
                    default:     p = seed[31:24];
                endcase
                blk[y * side + x] = p;
            end
        end
        for (y = 0; y < side; y++) begin
            for (x = 0; x < side; x++) begin
                p = blk[y * side + x];
                e = p;
                if (mode == sao_pkg::MODE_BAND) begin
                    e = band_pixel(p, cases[c].band_pos, cases[c].offsets);
                end
                else if (mode == sao_pkg::MODE_EDGE && x != 0 && x != side - 1) begin
                    e = edge_pixel(p, blk[y * side + x - 1], blk[y * side + x + 1],
                                   cases[c].offsets);
                end
                exp_pix_q.push_back(e);
                exp_addr_q.push_back(pixel_addr(cases[c].lx, cases[c].ly, side, x, y));
            end
        end
    endtask

    task automatic step_cycle();
        @(posedge clk);
        #1;
        in_en = 1'b0;
        check_busy(busy, busy_left > 0);
        if (busy_left > 0) begin
            busy_left--;
        end
    endtask

    task automatic drive_block(input int c);
        int side;
        int i;
        sao_pkg::sao_mode_e mode;
        side = block_side(cases[c].lcu_size);
        mode = expected_mode(cases[c].ipf_type, cases[c].wo_class);
        i = 0;
        while (i < side * side) begin
            step_cycle();
            seed = lcg_step(seed);
            if (busy === 1'b0 && (!cases[c].gaps || seed[31:30] != 2'b00)) begin
                in_en = 1'b1;
                din = blk[i];
                ipf_type = cases[c].ipf_type;
                ipf_wo_class = cases[c].wo_class;
                ipf_band_pos = cases[c].band_pos;
                ipf_offset = cases[c].offsets;
                lcu_x = cases[c].lx;
                lcu_y = cases[c].ly;
                lcu_size = cases[c].lcu_size;
                lat_q.push_back(mode == sao_pkg::MODE_EDGE ? -1 : cycle);
                if (i == side * side - 1) begin
                    busy_left = 4;  // Block drain
                end
                else if (mode == sao_pkg::MODE_EDGE && i % side == side - 1) begin
                    busy_left = 2;  // Row flush
                end
                i++;
            end
        end
    endtask

    // Output monitor
    initial begin
        sao_pkg::pixel_t exp_p;
        sao_pkg::addr_t exp_a;
        int issued;
        forever begin
            @(posedge clk);
            #1;
            if (!reset) begin
                check_finish(finish, last_addr_out);
                if (finish === 1'b1) begin
                    finish_cnt++;
                end
                last_addr_out = 1'b0;
                if (out_en === 1'b1) begin
                    if (exp_pix_q.size() == 0) begin
                        end_with_failure("Output seen while no pixel was pending");
                    end
                    exp_p = exp_pix_q.pop_front();
                    exp_a = exp_addr_q.pop_front();
                    check_addr(dout_addr, exp_a);
                    check_pixel(dout, exp_p, exp_a);
                    issued = lat_q.pop_front();
                    if (issued >= 0) begin
                        check_latency(cycle - issued, 3, exp_a);
                    end
                    last_addr_out = (exp_a == LAST_ADDR);
                end
                else if (out_en !== 1'b0) begin
                    end_with_failure("out_en is unknown after reset");
                end
            end
        end
    end

    initial begin
        int total;
        int c;
        @(negedge reset);
        total = 0;
        for (c = 0; c < NUM_CASES; c++) begin
            total += block_side(cases[c].lcu_size) * block_side(cases[c].lcu_size);
        end
        repeat (total * 4 * 4 + 1000) @(posedge clk);
        end_with_failure($sformatf("Timeout: %0d outputs still missing", exp_pix_q.size()));
    end

    initial begin
        int c;
        int idle;
        reset = 1'b1;
        in_en = 1'b0;
        din = '0;
        ipf_type = '0;
        ipf_band_pos = '0;
        ipf_wo_class = 1'b0;
        ipf_offset = '0;
        lcu_x = '0;
        lcu_y = '0;
        lcu_size = '0;
        load_cases();
        repeat (10) @(posedge clk);
        #1;
        reset = 1'b0;
        for (c = 0; c < NUM_CASES; c++) begin
            build_block(c);
            drive_block(c);
        end
        idle = 0;
        while (exp_pix_q.size() != 0 || idle < 6) begin
            step_cycle();
            if (exp_pix_q.size() == 0) begin
                idle++;
            end
        end
        if (finish_cnt != 1) begin
            end_with_failure($sformatf("Finish pulsed %0d times instead of once", finish_cnt));
        end
        else begin
            $display("TESTBENCH PASSED");
            $finish;
        end
    end

endmodule

`default_nettype wire

/* all.f */
+incdir+design
+incdir+verification
design/sao_pkg.sv
design/sao_ifs.sv
design/sao_scanner.sv
design/sao_classifier.sv
design/sao_writer.sv
design/sao_filter.sv
verification/tb_sao_filter.sv

/* Makefile */
VERILATOR  = verilator
TOP        = tb_sao_filter
FILELIST   = all.f
BUILD_DIR  = obj_dir
LINT_FLAGS = --lint-only --timing
SIM_FLAGS  = --binary --timing -j 0

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)
